// File: project.f
rtl/vic_pkg.sv
rtl/cpu_bus_if.sv
rtl/decoded_bus_if.sv
rtl/vic_clock_enables.sv
rtl/cpu_bus_latch.sv
rtl/bus_decoder.sv
rtl/vic_register_file.sv
rtl/cpu_read_mux.sv
rtl/vic20_bus_glue.sv
sim/tb_vic20_bus_glue.sv

// File: rtl/bus_decoder.sv
`default_nettype none

module bus_decoder (
   input  wire            clk25,
   input  wire            pwr_up_reset_n,
   cpu_bus_if.decode      bus,
   output logic           o_ram_we,
   decoded_bus_if.decoder dec
);
   import vic_pkg::*;

   logic vic_hit;
   logic via_hit;
   logic rom_hit;
   logic wr_ok;

   assign vic_hit = bus.addr[15:8] == vic_page;
   assign via_hit = bus.addr[15:8] == via_page;
   assign rom_hit = rom_nibbles[bus.addr[15:12]];  // 8, C, D, E, F
   assign wr_ok   = bus.we && bus.hard_reset_n;    // No writes while CPU in hard reset

   // ====================
   // Region flags
   // ====================
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_ram_we       <= 1'b0;
         dec.we         <= 1'b0;
         dec.vic_we     <= 1'b0;
         dec.via1_sel   <= 1'b0;
         dec.via2_sel   <= 1'b0;
         dec.raster_sel <= 1'b0;
      end else begin
         o_ram_we       <= wr_ok && !rom_hit;   // I/O pages also land in RAM
         dec.we         <= wr_ok;
         dec.vic_we     <= wr_ok && vic_hit;
         dec.via1_sel   <= via_hit && bus.addr[4];
         dec.via2_sel   <= via_hit && bus.addr[5];
         dec.raster_sel <= bus.addr == raster_addr;
      end
   end

   // Index and data follow along
   always_ff @(posedge clk25) begin
      dec.reg_idx   <= bus.addr[3:0];
      dec.wdata.raw <= bus.wdata;
   end

   // ROM is never written, judged on the bus the flag came from
   a_no_rom_write : assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      o_ram_we |-> !rom_nibbles[$past(bus.addr[15:12])]);

endmodule

`default_nettype wire

// File: rtl/cpu_bus_if.sv
`default_nettype none

// Latched CPU bus, held between CPU enables
interface cpu_bus_if;

   logic [15:0] addr;
   logic [7:0]  wdata;
   logic        we;            // Write strobe as latched
   logic        hard_reset_n;  // Low until first enable after power-up

   modport latch (
      output addr,
      output wdata,
      output we,
      output hard_reset_n
   );

   modport decode (
      input addr,
      input wdata,
      input we,
      input hard_reset_n
   );

endinterface

`default_nettype wire

// File: rtl/cpu_bus_latch.sv
`default_nettype none

module cpu_bus_latch (
   input  wire         clk25,
   input  wire         pwr_up_reset_n,
   input  wire         i_cpu_clken,
   input  wire  [15:0] i_cpu_addr,
   input  wire  [7:0]  i_cpu_dout,
   input  wire         i_cpu_we,
   input  wire         i_btn_reset_n,
   output logic        o_cpu_reset,
   cpu_bus_if.latch    bus
);

   // ====================
   // Control: strobe and hard reset
   // ====================
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         bus.we           <= 1'b0;
         bus.hard_reset_n <= 1'b0;
      end else if (i_cpu_clken) begin
         bus.we           <= i_cpu_we;
         bus.hard_reset_n <= 1'b1;   // Released on first enable after power-up
      end
   end

   // ====================
   // Address and write data
   // ====================
   always_ff @(posedge clk25) begin
      if (i_cpu_clken) begin
         bus.addr  <= i_cpu_addr;
         bus.wdata <= i_cpu_dout;
      end
   end

   // CPU held in reset by either source
   assign o_cpu_reset = !bus.hard_reset_n || !i_btn_reset_n;

endmodule

`default_nettype wire

// File: rtl/cpu_read_mux.sv
`default_nettype none

module cpu_read_mux (
   input  wire           clk25,
   input  wire           pwr_up_reset_n,
   decoded_bus_if.reader dec,
   input  wire  [5:0]    i_btn,          // Buttons 1..6, active high
   input  wire  [7:0]    i_kbd_row,
   input  wire  [7:0]    i_raster_line,
   input  wire  [7:0]    i_via1_dout,
   input  wire  [7:0]    i_via2_dout,
   input  wire  [7:0]    i_ram_dout,
   output logic [7:0]    o_cpu_din
);
   import vic_pkg::*;

   logic [3:0] ddr1a_5_2;  // VIA1 DDRA, joystick bits only
   logic       ddr2b_7;    // VIA2 DDRB, button 6 bit only
   logic [7:0] ddr2a;      // VIA2 DDRA, keyboard rows
   logic       port_a;
   logic [7:0] joy_word;
   logic [7:0] btn6_word;
   logic [7:0] kbd_word;

   assign port_a    = (dec.reg_idx == via_ora) || (dec.reg_idx == via_ora_nh);
   assign joy_word  = {2'b11, ~i_btn[0], ~i_btn[4], ~i_btn[3], ~i_btn[2], 2'b11};
   assign btn6_word = {~i_btn[5], 7'h7F};
   assign kbd_word  = {i_kbd_row[0], i_kbd_row[6:1], i_kbd_row[7]};  // Row wiring order

   // ====================
   // DDR shadows
   // ====================
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         ddr1a_5_2 <= '0;
         ddr2b_7   <= 1'b0;
         ddr2a     <= '0;
      end else if (dec.we) begin
         if (dec.via1_sel && dec.reg_idx == via_ddra)
            ddr1a_5_2 <= dec.wdata.raw[5:2];
         if (dec.via2_sel && dec.reg_idx == via_ddrb)
            ddr2b_7 <= dec.wdata.raw[7];
         if (dec.via2_sel && dec.reg_idx == via_ddra)
            ddr2a <= dec.wdata.raw;
      end
   end

   // Read data, highest priority first
   always_ff @(posedge clk25) begin
      if (dec.raster_sel)
         o_cpu_din <= i_raster_line;
      else if (dec.via1_sel && port_a && ddr1a_5_2 == 4'd0)
         o_cpu_din <= joy_word;     // Joystick on port A inputs
      else if (dec.via1_sel)
         o_cpu_din <= i_via1_dout;
      else if (dec.via2_sel && dec.reg_idx == via_orb && !ddr2b_7)
         o_cpu_din <= btn6_word;
      else if (dec.via2_sel && port_a && ddr2a == 8'h00)
         o_cpu_din <= kbd_word;
      else if (dec.via2_sel)
         o_cpu_din <= i_via2_dout;
      else
         o_cpu_din <= i_ram_dout;
   end

endmodule

`default_nettype wire

// File: rtl/decoded_bus_if.sv
`default_nettype none

// Decoded bus, one cycle behind the latch
interface decoded_bus_if;
   import vic_pkg::*;

   logic [3:0]    reg_idx;     // Low address nibble
   vic_reg_data_u wdata;
   logic          we;          // Any qualified CPU write
   logic          vic_we;      // Write to the VIC page
   logic          via1_sel;
   logic          via2_sel;
   logic          raster_sel;

   modport decoder (
      output reg_idx, wdata, we, vic_we, via1_sel, via2_sel, raster_sel
   );

   modport regs (
      input reg_idx, wdata, vic_we
   );

   modport reader (
      input reg_idx, wdata, we, via1_sel, via2_sel, raster_sel
   );

endinterface

`default_nettype wire

// File: rtl/vic20_bus_glue.sv
`default_nettype none

module vic20_bus_glue (
   input  wire         clk25,
   input  wire         pwr_up_reset_n,
   input  wire  [1:0]  i_turbo,
   // CPU side
   input  wire  [15:0] i_cpu_addr,
   input  wire  [7:0]  i_cpu_dout,
   input  wire         i_cpu_we,
   input  wire         i_btn_reset_n,
   input  wire  [5:0]  i_btn,
   input  wire  [7:0]  i_kbd_row,
   input  wire  [7:0]  i_raster_line,
   input  wire  [7:0]  i_via1_dout,
   input  wire  [7:0]  i_via2_dout,
   input  wire  [7:0]  i_ram_dout,
   output logic        o_cpu_clken,
   output logic        o_via_clken,
   output logic        o_via4_clken,
   output logic        o_cpu_reset,
   output logic        o_ram_we,
   output logic [7:0]  o_cpu_din,
   // VIC registers
   output logic [15:0] o_screen_addr,
   output logic [15:0] o_char_rom_addr,
   output logic [15:0] o_color_ram_addr,
   output logic [6:0]  o_xorigin,
   output logic [7:0]  o_yorigin,
   output logic [6:0]  o_cols,
   output logic [6:0]  o_rows,
   output logic        o_chars8x16,
   output logic [2:0]  o_border_color,
   output logic [3:0]  o_back_color,
   output logic        o_inverted,
   output logic [3:0]  o_aux_color,
   output logic [7:0]  o_bass,
   output logic [7:0]  o_alto,
   output logic [7:0]  o_soprano,
   output logic [7:0]  o_noise,
   output logic [3:0]  o_volume
);

   cpu_bus_if     cpu_bus ();
   decoded_bus_if dec_bus ();

   vic_clock_enables vic_clock_enables_i (
      .clk25, .pwr_up_reset_n, .i_turbo,
      .o_cpu_clken, .o_via_clken, .o_via4_clken
   );

   cpu_bus_latch cpu_bus_latch_i (
      .clk25, .pwr_up_reset_n,
      .i_cpu_clken (o_cpu_clken),
      .i_cpu_addr, .i_cpu_dout, .i_cpu_we, .i_btn_reset_n,
      .o_cpu_reset,
      .bus         (cpu_bus.latch)
   );

   bus_decoder bus_decoder_i (
      .clk25, .pwr_up_reset_n,
      .bus      (cpu_bus.decode),
      .o_ram_we,
      .dec      (dec_bus.decoder)
   );

   vic_register_file vic_register_file_i (
      .clk25, .pwr_up_reset_n,
      .dec (dec_bus.regs),
      .o_screen_addr, .o_char_rom_addr, .o_color_ram_addr,
      .o_xorigin, .o_yorigin, .o_cols, .o_rows, .o_chars8x16,
      .o_border_color, .o_back_color, .o_inverted, .o_aux_color,
      .o_bass, .o_alto, .o_soprano, .o_noise, .o_volume
   );

   cpu_read_mux cpu_read_mux_i (
      .clk25, .pwr_up_reset_n,
      .dec (dec_bus.reader),
      .i_btn, .i_kbd_row, .i_raster_line,
      .i_via1_dout, .i_via2_dout, .i_ram_dout,
      .o_cpu_din
   );

endmodule

`default_nettype wire

// File: rtl/vic_clock_enables.sv
`default_nettype none

module vic_clock_enables (
   input  wire        clk25,
   input  wire        pwr_up_reset_n,
   input  wire  [1:0] i_turbo,
   output logic       o_cpu_clken,
   output logic       o_via_clken,
   output logic       o_via4_clken
);
   import vic_pkg::*;

   logic [4:0] clkdiv;   // 0..24
   logic       cpu_next;
   logic       via4_next;

   // Decode the count for the chosen speed, nothing from 16 up
   always_comb begin
      case (i_turbo)
         turbo_1mhz: begin
            cpu_next  = (clkdiv[3:0] == 4'd0) && !clkdiv[4];  // count 0
            via4_next = (clkdiv[1:0] == 2'd0) && !clkdiv[4];  // 0, 4, 8, 12
         end
         turbo_2mhz: begin
            cpu_next  = (clkdiv[2:0] == 3'd0) && !clkdiv[4];  // 0, 8
            via4_next = !clkdiv[0] && !clkdiv[4];             // even counts
         end
         default: begin  // 4 MHz
            cpu_next  = (clkdiv[1:0] == 2'd0) && !clkdiv[4];
            via4_next = !clkdiv[4];
         end
      endcase
   end

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         clkdiv       <= '0;
         o_cpu_clken  <= 1'b0;
         o_via_clken  <= 1'b0;
         o_via4_clken <= 1'b0;
      end else begin
         if (clkdiv == clkdiv_modulus - 5'd1)
            clkdiv <= '0;
         else
            clkdiv <= clkdiv + 5'd1;
         o_cpu_clken  <= cpu_next;   // One-cycle pulses
         o_via_clken  <= cpu_next;   // VIAs tick with the CPU
         o_via4_clken <= via4_next;
      end
   end

   // The 4x enable is a superset of the CPU enable at every speed
   a_cpu_within_via4 : assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      o_cpu_clken |-> o_via4_clken);

endmodule

`default_nettype wire

// File: rtl/vic_pkg.sv
`default_nettype none

package vic_pkg;

   // ====================
   // Clock divider
   // ====================
   localparam logic [4:0] clkdiv_modulus = 5'd25;  // clk25 cycles per period

   localparam logic [1:0] turbo_1mhz = 2'd0;
   localparam logic [1:0] turbo_2mhz = 2'd1;
   localparam logic [1:0] turbo_4mhz = 2'd2;  // codes above this run at 4 MHz too

   // ====================
   // Address map
   // ====================
   localparam logic [7:0]  vic_page    = 8'h90;
   localparam logic [7:0]  via_page    = 8'h91;
   localparam logic [15:0] raster_addr = 16'h9004;

   // One bit per upper address nibble, set where ROM lives (8, C..F)
   localparam logic [15:0] rom_nibbles = 16'hF100;

   // VIC register indices
   localparam logic [3:0] reg_xorigin = 4'h0;
   localparam logic [3:0] reg_yorigin = 4'h1;
   localparam logic [3:0] reg_cols    = 4'h2;
   localparam logic [3:0] reg_rows    = 4'h3;
   localparam logic [3:0] reg_mem     = 4'h5;
   localparam logic [3:0] reg_bass    = 4'hA;
   localparam logic [3:0] reg_alto    = 4'hB;
   localparam logic [3:0] reg_soprano = 4'hC;
   localparam logic [3:0] reg_noise   = 4'hD;
   localparam logic [3:0] reg_volume  = 4'hE;
   localparam logic [3:0] reg_color   = 4'hF;

   // 6522 register indices
   localparam logic [3:0] via_orb    = 4'h0;
   localparam logic [3:0] via_ora    = 4'h1;
   localparam logic [3:0] via_ddrb   = 4'h2;
   localparam logic [3:0] via_ddra   = 4'h3;
   localparam logic [3:0] via_ora_nh = 4'hF;  // port A, no handshake

   // ====================
   // Reset values
   // ====================
   localparam logic [15:0] screen_addr_rst    = 16'h1E00;
   localparam logic [15:0] char_rom_addr_rst  = 16'h8000;
   localparam logic [15:0] color_ram_addr_rst = 16'h9400;
   localparam logic [6:0]  xorigin_rst        = 7'd12;
   localparam logic [7:0]  yorigin_rst        = 8'd38;
   localparam logic [6:0]  cols_rst           = 7'd22;
   localparam logic [6:0]  rows_rst           = 7'd23;

   // CPU write byte, seen per target register
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic       addr9;       // video address bit 9
         logic [6:0] cols;
      } geom;                     // register 2
      struct packed {
         logic       scr_a15_n;   // screen a15, inverted
         logic [2:0] scr_a12_10;
         logic       chr_a15_n;   // char ROM a15, inverted
         logic [2:0] chr_a12_10;
      } mem;                      // register 5
      struct packed {
         logic [3:0] back;
         logic       inverted;
         logic [2:0] border;
      } color;                    // register 0xF
   } vic_reg_data_u;

endpackage

`default_nettype wire

// File: rtl/vic_register_file.sv
`default_nettype none

module vic_register_file (
   input  wire          clk25,
   input  wire          pwr_up_reset_n,
   decoded_bus_if.regs  dec,
   // Video
   output logic [15:0]  o_screen_addr,
   output logic [15:0]  o_char_rom_addr,
   output logic [15:0]  o_color_ram_addr,
   output logic [6:0]   o_xorigin,
   output logic [7:0]   o_yorigin,
   output logic [6:0]   o_cols,
   output logic [6:0]   o_rows,
   output logic         o_chars8x16,
   output logic [2:0]   o_border_color,
   output logic [3:0]   o_back_color,
   output logic         o_inverted,
   output logic [3:0]   o_aux_color,
   // Sound
   output logic [7:0]   o_bass,
   output logic [7:0]   o_alto,
   output logic [7:0]   o_soprano,
   output logic [7:0]   o_noise,
   output logic [3:0]   o_volume
);
   import vic_pkg::*;

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_screen_addr    <= screen_addr_rst;
         o_char_rom_addr  <= char_rom_addr_rst;
         o_color_ram_addr <= color_ram_addr_rst;
         o_xorigin        <= xorigin_rst;
         o_yorigin        <= yorigin_rst;
         o_cols           <= cols_rst;
         o_rows           <= rows_rst;
         o_chars8x16      <= 1'b0;
         o_border_color   <= '0;
         o_back_color     <= '0;
         o_inverted       <= 1'b0;
         o_aux_color      <= '0;
         o_bass           <= '0;
         o_alto           <= '0;
         o_soprano        <= '0;
         o_noise          <= '0;
         o_volume         <= '0;
      end else if (dec.vic_we) begin
         case (dec.reg_idx)
            // ====================
            // Video
            // ====================
            reg_xorigin: o_xorigin <= dec.wdata.raw[6:0];
            reg_yorigin: o_yorigin <= dec.wdata.raw;
            reg_cols: begin
               o_screen_addr[9]    <= dec.wdata.geom.addr9;  // Shared by both
               o_color_ram_addr[9] <= dec.wdata.geom.addr9;
               o_cols              <= dec.wdata.geom.cols;
            end
            reg_rows: begin
               o_chars8x16 <= dec.wdata.raw[0];  // Overlaps the row count
               o_rows      <= dec.wdata.raw[6:0];
            end
            reg_mem: begin
               o_screen_addr[15]      <= ~dec.wdata.mem.scr_a15_n;
               o_screen_addr[12:10]   <= dec.wdata.mem.scr_a12_10;
               o_char_rom_addr[15]    <= ~dec.wdata.mem.chr_a15_n;
               o_char_rom_addr[12:10] <= dec.wdata.mem.chr_a12_10;
            end
            reg_color: begin
               o_back_color   <= dec.wdata.color.back;
               o_inverted     <= dec.wdata.color.inverted;
               o_border_color <= dec.wdata.color.border;
            end
            // ====================
            // Sound
            // ====================
            reg_bass:    o_bass    <= dec.wdata.raw;
            reg_alto:    o_alto    <= dec.wdata.raw;
            reg_soprano: o_soprano <= dec.wdata.raw;
            reg_noise:   o_noise   <= dec.wdata.raw;
            reg_volume: begin
               o_aux_color <= dec.wdata.raw[7:4];  // Color nibble shares the register
               o_volume    <= dec.wdata.raw[3:0];
            end
            default: ;  // 4, 6..9 are read-only or unused
         endcase
      end
   end

   // Registers only move on a decoded VIC write
   a_hold_without_we : assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      !dec.vic_we |=> $stable({o_screen_addr, o_char_rom_addr, o_color_ram_addr,
                               o_xorigin, o_yorigin, o_cols, o_rows, o_chars8x16,
                               o_border_color, o_back_color, o_inverted, o_aux_color,
                               o_bass, o_alto, o_soprano, o_noise, o_volume}));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
   --top-module tb_vic20_bus_glue -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build error"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
exit 0

// File: sim/tb_vic20_bus_glue.sv
`default_nettype none

module tb_vic20_bus_glue;
   timeunit 1ns;
   timeprecision 100ps;

   logic        clk25;
   logic        pwr_up_reset_n;
   logic [1:0]  i_turbo;
   logic [15:0] i_cpu_addr;
   logic [7:0]  i_cpu_dout;
   logic        i_cpu_we;
   logic        i_btn_reset_n;
   logic [5:0]  i_btn;
   logic [7:0]  i_kbd_row;
   logic [7:0]  i_raster_line;
   logic [7:0]  i_via1_dout;
   logic [7:0]  i_via2_dout;
   logic [7:0]  i_ram_dout;
   logic        o_cpu_clken;
   logic        o_via_clken;
   logic        o_via4_clken;
   logic        o_cpu_reset;
   logic        o_ram_we;
   logic [7:0]  o_cpu_din;
   logic [15:0] o_screen_addr;
   logic [15:0] o_char_rom_addr;
   logic [15:0] o_color_ram_addr;
   logic [6:0]  o_xorigin;
   logic [7:0]  o_yorigin;
   logic [6:0]  o_cols;
   logic [6:0]  o_rows;
   logic        o_chars8x16;
   logic [2:0]  o_border_color;
   logic [3:0]  o_back_color;
   logic        o_inverted;
   logic [3:0]  o_aux_color;
   logic [7:0]  o_bass;
   logic [7:0]  o_alto;
   logic [7:0]  o_soprano;
   logic [7:0]  o_noise;
   logic [3:0]  o_volume;

   string       test_name;
   logic        ram_we_seen;   // o_ram_we for the access just run
   logic [3:0]  vic_idx [11] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'hA, 4'hB, 4'hC, 4'hD,
                                  4'hE, 4'hF};

   // ====================
   // Expected VIC state
   // ====================
   logic [15:0] exp_screen;
   logic [15:0] exp_char;
   logic [15:0] exp_color;
   logic [6:0]  exp_xorigin;
   logic [7:0]  exp_yorigin;
   logic [6:0]  exp_cols;
   logic [6:0]  exp_rows;
   logic        exp_c8x16;
   logic [2:0]  exp_border;
   logic [3:0]  exp_back;
   logic        exp_inverted;
   logic [3:0]  exp_aux;
   logic [7:0]  exp_bass;
   logic [7:0]  exp_alto;
   logic [7:0]  exp_soprano;
   logic [7:0]  exp_noise;
   logic [3:0]  exp_volume;

   vic20_bus_glue vic20_bus_glue_i (.*);

   initial begin
      clk25 = 1'b0;
      forever #2 clk25 = ~clk25;   // 4 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_val(input string field, input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp)
         else abort_run($sformatf("MISMATCH %s/%s: expected 0x%0h, actual 0x%0h",
                                  test_name, field, exp, act));
   endtask

   // One edge on with inputs and outputs settled
   task automatic next_cycle();
      @(posedge clk25);
      #1;
   endtask

   // Returns when the coming edge latches the CPU bus
   task automatic wait_cpu_enable();
      int n;
      n = 0;
      while (!o_cpu_clken && n < 100) begin
         next_cycle();
         n++;
      end
      if (!o_cpu_clken)
         abort_run("Timeout: no CPU enable within 100 cycles");
   endtask

   // One CPU access; returns once register file and read data are updated
   task automatic run_access(input logic [15:0] addr, input logic [7:0] data, input logic we);
      i_cpu_addr = addr;
      i_cpu_dout = data;
      i_cpu_we   = we;
      wait_cpu_enable();
      next_cycle();               // Latched
      next_cycle();               // Decoded
      ram_we_seen = o_ram_we;
      next_cycle();               // Registers and o_cpu_din
      i_cpu_we = 1'b0;
   endtask

   // Pulses in one full divider period
   task automatic count_enables(input logic [1:0] speed, input int exp_cpu, input int exp_4x);
      int n_cpu;
      int n_via;
      int n_4x;
      i_turbo = speed;
      next_cycle();
      next_cycle();
      n_cpu = 0;
      n_via = 0;
      n_4x  = 0;
      repeat (25) begin
         next_cycle();
         if (o_cpu_clken)
            n_cpu++;
         if (o_via_clken)
            n_via++;
         if (o_via4_clken)
            n_4x++;
      end
      check_val("cpu_pulses", 16'(exp_cpu), 16'(n_cpu));
      check_val("via_pulses", 16'(exp_cpu), 16'(n_via));
      check_val("via4_pulses", 16'(exp_4x), 16'(n_4x));
   endtask

   task automatic init_expect();
      exp_screen   = 16'h1E00;
      exp_char     = 16'h8000;
      exp_color    = 16'h9400;
      exp_xorigin  = 7'd12;
      exp_yorigin  = 8'd38;
      exp_cols     = 7'd22;
      exp_rows     = 7'd23;
      exp_c8x16    = 1'b0;
      exp_border   = '0;
      exp_back     = '0;
      exp_inverted = 1'b0;
      exp_aux      = '0;
      exp_bass     = '0;
      exp_alto     = '0;
      exp_soprano  = '0;
      exp_noise    = '0;
      exp_volume   = '0;
   endtask

   // Field split of a VIC write byte
   task automatic apply_vic_write(input logic [3:0] idx, input logic [7:0] d);
      case (idx)
         4'h0: exp_xorigin = d[6:0];
         4'h1: exp_yorigin = d;
         4'h2: begin
            exp_screen[9] = d[7];   // Video a9 for screen and color RAM
            exp_color[9]  = d[7];
            exp_cols      = d[6:0];
         end
         4'h3: begin
            exp_c8x16 = d[0];
            exp_rows  = d[6:0];
         end
         4'h5: begin
            exp_screen[15]    = ~d[7];
            exp_screen[12:10] = d[6:4];
            exp_char[15]      = ~d[3];
            exp_char[12:10]   = d[2:0];
         end
         4'hA: exp_bass    = d;
         4'hB: exp_alto    = d;
         4'hC: exp_soprano = d;
         4'hD: exp_noise   = d;
         4'hE: begin
            exp_aux    = d[7:4];
            exp_volume = d[3:0];
         end
         4'hF: begin
            exp_back     = d[7:4];
            exp_inverted = d[3];
            exp_border   = d[2:0];
         end
         default: ;
      endcase
   endtask

   task automatic check_regs();
      check_val("screen_addr", exp_screen, o_screen_addr);
      check_val("char_rom_addr", exp_char, o_char_rom_addr);
      check_val("color_ram_addr", exp_color, o_color_ram_addr);
      check_val("xorigin", 16'(exp_xorigin), 16'(o_xorigin));
      check_val("yorigin", 16'(exp_yorigin), 16'(o_yorigin));
      check_val("cols", 16'(exp_cols), 16'(o_cols));
      check_val("rows", 16'(exp_rows), 16'(o_rows));
      check_val("chars8x16", 16'(exp_c8x16), 16'(o_chars8x16));
      check_val("border", 16'(exp_border), 16'(o_border_color));
      check_val("back", 16'(exp_back), 16'(o_back_color));
      check_val("inverted", 16'(exp_inverted), 16'(o_inverted));
      check_val("aux", 16'(exp_aux), 16'(o_aux_color));
      check_val("bass", 16'(exp_bass), 16'(o_bass));
      check_val("alto", 16'(exp_alto), 16'(o_alto));
      check_val("soprano", 16'(exp_soprano), 16'(o_soprano));
      check_val("noise", 16'(exp_noise), 16'(o_noise));
      check_val("volume", 16'(exp_volume), 16'(o_volume));
   endtask

   function automatic logic [7:0] rand_byte();
      int unsigned r;
      r = $urandom();
      return r[7:0];
   endfunction

   function automatic logic is_rom_nibble(input logic [3:0] nib);
      return (nib == 4'h8) || (nib >= 4'hC);   // 8 and C..F
   endfunction

   // VIAs tick with the CPU
   a_via_with_cpu : assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      o_cpu_clken == o_via_clken)
      else abort_run("VIA enable and CPU enable disagree");

   a_clken_pulse : assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      o_cpu_clken |=> !o_cpu_clken)
      else abort_run("CPU enable stayed high for more than one cycle");

   initial begin
      int unsigned rnd;
      int          nib;
      logic [15:0] addr;
      logic [7:0]  d;
      void'($urandom(53995));   // Single seed for the run
      pwr_up_reset_n = 1'b0;
      i_turbo        = 2'd0;
      i_cpu_addr     = '0;
      i_cpu_dout     = '0;
      i_cpu_we       = 1'b0;
      i_btn_reset_n  = 1'b1;
      i_btn          = '0;
      i_kbd_row      = '0;
      i_raster_line  = '0;
      i_via1_dout    = '0;
      i_via2_dout    = '0;
      i_ram_dout     = '0;
      init_expect();
      repeat (16) @(posedge clk25);
      #1;
      pwr_up_reset_n = 1'b1;

      // ====================
      // Reset state
      // ====================
      test_name = "reset";
      check_val("ram_we", 16'd0, 16'(o_ram_we));
      check_val("cpu_reset", 16'd1, 16'(o_cpu_reset));
      check_regs();
      wait_cpu_enable();
      next_cycle();                          // Hard reset released here
      check_val("cpu_reset_release", 16'd0, 16'(o_cpu_reset));
      i_btn_reset_n = 1'b0;
      next_cycle();
      check_val("btn_reset", 16'd1, 16'(o_cpu_reset));
      i_btn_reset_n = 1'b1;
      next_cycle();
      check_val("btn_release", 16'd0, 16'(o_cpu_reset));

      test_name = "enables";
      count_enables(2'd0, 1, 4);
      count_enables(2'd1, 2, 8);
      count_enables(2'd2, 4, 16);
      count_enables(2'd3, 4, 16);            // Stays at 4 MHz from here on

      // ====================
      // VIC writes
      // ====================
      test_name = "vic_write";
      foreach (vic_idx[k]) begin
         repeat (2) begin
            d = rand_byte();
            run_access({12'h900, vic_idx[k]}, d, 1'b1);
            apply_vic_write(vic_idx[k], d);
            check_val("ram_we", 16'd1, 16'(ram_we_seen));   // I/O page lands in RAM too
            check_regs();
         end
      end

      test_name = "ram_we";
      for (nib = 0; nib < 16; nib++) begin
         rnd  = $urandom();
         addr = {nib[3:0], rnd[11:0]};
         if (nib == 9)
            addr[11:8] = 4'h4;               // Away from VIC and VIA pages
         run_access(addr, rand_byte(), 1'b1);
         check_val("write", 16'(!is_rom_nibble(nib[3:0])), 16'(ram_we_seen));
         run_access(addr, 8'h00, 1'b0);
         check_val("read", 16'd0, 16'(ram_we_seen));
      end

      // ====================
      // Read data priority
      // ====================
      test_name     = "read_mux";
      i_raster_line = rand_byte();
      i_via1_dout   = rand_byte();
      i_via2_dout   = rand_byte();
      i_ram_dout    = rand_byte();
      i_kbd_row     = rand_byte();
      rnd           = $urandom();
      i_btn         = rnd[5:0];
      run_access(16'h9004, 8'h00, 1'b0);
      check_val("raster", 16'(i_raster_line), 16'(o_cpu_din));
      d = {2'b11, ~i_btn[0], ~i_btn[4], ~i_btn[3], ~i_btn[2], 2'b11};   // Joystick word
      run_access(16'h9111, 8'h00, 1'b0);
      check_val("joy_ora", 16'(d), 16'(o_cpu_din));
      run_access(16'h911F, 8'h00, 1'b0);
      check_val("joy_ora_nh", 16'(d), 16'(o_cpu_din));
      run_access(16'h9113, rand_byte() | 8'h04, 1'b1);                  // DDRA bit 2 set
      run_access(16'h9111, 8'h00, 1'b0);
      check_val("via1_data", 16'(i_via1_dout), 16'(o_cpu_din));
      run_access(16'h9120, 8'h00, 1'b0);
      check_val("btn6", 16'({~i_btn[5], 7'h7F}), 16'(o_cpu_din));
      run_access(16'h9122, rand_byte() | 8'h80, 1'b1);
      run_access(16'h9120, 8'h00, 1'b0);
      check_val("via2_orb", 16'(i_via2_dout), 16'(o_cpu_din));
      d = {i_kbd_row[0], i_kbd_row[6:1], i_kbd_row[7]};                 // Row 0 to the top
      run_access(16'h9121, 8'h00, 1'b0);
      check_val("kbd_row", 16'(d), 16'(o_cpu_din));
      run_access(16'h9123, rand_byte() | 8'h01, 1'b1);
      run_access(16'h9121, 8'h00, 1'b0);
      check_val("via2_ora", 16'(i_via2_dout), 16'(o_cpu_din));
      run_access(16'h1234, 8'h00, 1'b0);
      check_val("ram", 16'(i_ram_dout), 16'(o_cpu_din));
      run_access(16'h9000, 8'h00, 1'b0);
      check_val("vic_page_ram", 16'(i_ram_dout), 16'(o_cpu_din));

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire
